//--- crop_blank.f
+incdir+.
video_timing_pkg.sv
key_cmd_pkg.sv
raster_if.sv
crop_if.sv
raster_measure.sv
crop_keys.sv
blank_gen.sv
mode_snapshot.sv
crop_blank.sv
tb_crop_blank.sv

//--- crop_blank_tests.txt
// cols: line_len hsync hbl_end hbl_start | rows vsync vbl_end vbl_start | frames nkeys
// keys[8] (type<<8|code) | exp hbl_l hbl_r vbl_t vbl_b hsize vsize changes de_px de_lines
6
64 8 18 58 28 3 8 24 3 0 0 0 0 0 0 0 0 0 0 0 0 0 40 1c 2 40 1c
64 8 18 58 28 3 8 24 3 3 34c 34f 34f 0 0 0 0 0 8 0 1 0 40 1c 2 38 1b
64 8 18 58 28 3 8 24 3 5 364 34c 34f 3e4 34d 0 0 0 8 4 0 1 40 1c 2 3c 1d
64 8 18 58 28 3 8 24 3 4 341 14c 14f 24e 0 0 0 0 0 0 0 0 40 1c 2 40 1c
78 a 1e 6e 32 4 a 2c 3 0 0 0 0 0 0 0 0 0 0 0 0 0 50 22 3 50 22
64 8 18 58 28 3 8 24 3 0 0 0 0 0 0 0 0 0 0 0 0 0 40 1c 4 40 1c

//--- tb_crop_blank.sv
////////////////////
// testbench for the crop and display-enable top
// raster generator, key driver, checks, watchdog
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_crop_blank;

	localparam int TEST_W = 27;   // words per test vector
	localparam int CLK_NS = 8;

	logic        clk_28;
	logic        arst_n;
	logic        hsync_n, vsync_n, hblank, vblank;
	logic        key_strobe;
	logic [1:0]  key_type;
	logic [7:0]  key_code;
	logic        de;
	logic [11:0] snap_hbl_l, snap_hbl_r, snap_vbl_t, snap_vbl_b;
	logic [11:0] snap_hsize, snap_vsize;
	logic [6:0]  size_changes;

	logic [15:0] vec [0:255];   // test vectors
	logic [31:0] rng;
	longint      wd_limit;      // watchdog time in ns

	crop_blank i_crop_blank (
		.clk_28       (clk_28),
		.arst_n       (arst_n),
		.hsync_n      (hsync_n),
		.vsync_n      (vsync_n),
		.hblank       (hblank),
		.vblank       (vblank),
		.key_strobe   (key_strobe),
		.key_type     (key_type),
		.key_code     (key_code),
		.de           (de),
		.snap_hbl_l   (snap_hbl_l),
		.snap_hbl_r   (snap_hbl_r),
		.snap_vbl_t   (snap_vbl_t),
		.snap_vbl_b   (snap_vbl_b),
		.snap_hsize   (snap_hsize),
		.snap_vsize   (snap_vsize),
		.size_changes (size_changes)
	);

	initial begin
		clk_28 = 1'b0;
		forever #(CLK_NS / 2) clk_28 = ~clk_28;   // 125 MHz sim clock
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_now(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic int word(input int idx);
		return int'(vec[idx]);
	endfunction

	////////////////////
	// one test of several raster frames with keys in vsync
	task automatic run_test(input int t);
		int base, len, hs, hbe, hbs, rows, vsr, vbe, vbs, frames, nkeys;
		int key_i, key_wait, row_de, de_lines;
		logic [15:0] k;
		base     = 1 + t * TEST_W;
		len      = word(base + 0);
		hs       = word(base + 1);
		hbe      = word(base + 2);
		hbs      = word(base + 3);
		rows     = word(base + 4);
		vsr      = word(base + 5);
		vbe      = word(base + 6);
		vbs      = word(base + 7);
		frames   = word(base + 8);
		nkeys    = word(base + 9);
		key_i    = 0;
		key_wait = 2;
		de_lines = 0;
		for (int fr = 0; fr < frames; fr++) begin
			de_lines = 0;
			for (int r = 0; r < rows; r++) begin
				row_de = 0;
				for (int p = 0; p < len; p++) begin
					@(negedge clk_28);
					if (de) row_de++;   // de of previous pixel
					if (t == 0 && fr == 0 && r < vbe)
						assert (!de && size_changes == 7'd0)
						else fail_now("de or size_changes active before the first frame start");
					hsync_n = (p >= hs);
					hblank  = (p < hbe) || (p >= hbs);
					vsync_n = (r >= vsr);
					vblank  = (r < vbe) || (r >= vbs);
					// key sequencer runs in the vsync rows of the first frame
					if (fr == 0 && r < vsr && key_i < nkeys) begin
						if (key_strobe) begin
							key_strobe = 1'b0;
							key_i++;
							rng      = xorshift(rng);
							key_wait = 1 + int'(rng[1:0]);   // random idle
						end else if (key_wait > 0) begin
							key_wait--;
						end else begin
							k          = vec[base + 10 + key_i];
							key_type   = k[9:8];
							key_code   = k[7:0];
							key_strobe = 1'b1;
						end
					end else begin
						key_strobe = 1'b0;
					end
				end
				if (fr == frames - 1 && row_de != 0) begin
					de_lines++;
					assert (row_de == word(base + 25))
					else fail_now($sformatf("test %0d row %0d de pixels %0d, expected %0d",
						t, r, row_de, word(base + 25)));
				end
			end
			if (fr == 0)
				assert (key_i == nkeys)
				else fail_now($sformatf("test %0d keys not all sent in vsync", t));
		end
		assert (de_lines == word(base + 26))
		else fail_now($sformatf("test %0d de lines %0d, expected %0d",
			t, de_lines, word(base + 26)));
		assert (snap_hbl_l == 12'(word(base + 18)) && snap_hbl_r == 12'(word(base + 19)) &&
			snap_vbl_t == 12'(word(base + 20)) && snap_vbl_b == 12'(word(base + 21)))
		else fail_now($sformatf("test %0d offsets l %0d r %0d t %0d b %0d", t,
			snap_hbl_l, snap_hbl_r, snap_vbl_t, snap_vbl_b));
		assert (snap_hsize == 12'(word(base + 22)) && snap_vsize == 12'(word(base + 23)))
		else fail_now($sformatf("test %0d size %0d x %0d, expected %0d x %0d", t,
			snap_hsize, snap_vsize, word(base + 22), word(base + 23)));
		assert (size_changes == 7'(word(base + 24)))
		else fail_now($sformatf("test %0d size_changes %0d, expected %0d", t,
			size_changes, word(base + 24)));
	endtask

	////////////////////
	// main sequence
	initial begin
		int n_tests;
		int b;
		arst_n     = 1'b0;
		hsync_n    = 1'b1;
		vsync_n    = 1'b1;
		hblank     = 1'b1;
		vblank     = 1'b1;
		key_strobe = 1'b0;
		key_type   = 2'd0;
		key_code   = 8'h00;
		rng        = 32'hf66f_9b5b;
		wd_limit   = 0;
		$readmemh("crop_blank_tests.txt", vec);
		n_tests = word(0);
		for (int t = 0; t < n_tests; t++) begin
			b = 1 + t * TEST_W;
			wd_limit += longint'(word(b + 8)) * word(b + 4) * word(b + 0) * CLK_NS * 2;
		end
		wd_limit += 100 * CLK_NS;   // reset and margin
		repeat (2) @(posedge clk_28);
		@(negedge clk_28);
		arst_n = 1'b1;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("Verification passed");
		$finish;
	end

	////////////////////
	// watchdog
	initial begin
		wait (wd_limit > 0);
		#(wd_limit);
		$display("timeout: raster tests did not finish in time");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- crop_blank.sv
////////////////////
// crop and display-enable top
// raster measure, key decoder, blanking, snapshot
////////////////////

`timescale 1ns/1ps
`default_nettype none

module crop_blank (
	input  logic        clk_28,         // pixel clock
	input  logic        arst_n,
	input  logic        hsync_n,
	input  logic        vsync_n,
	input  logic        hblank,
	input  logic        vblank,
	input  logic        key_strobe,
	input  logic [1:0]  key_type,
	input  logic [7:0]  key_code,
	output logic        de,
	output logic [11:0] snap_hbl_l,
	output logic [11:0] snap_hbl_r,
	output logic [11:0] snap_vbl_t,
	output logic [11:0] snap_vbl_b,
	output logic [11:0] snap_hsize,
	output logic [11:0] snap_vsize,
	output logic [6:0]  size_changes
);

	raster_if raster_bus ();   // measurements
	crop_if   crop_bus ();     // offsets

	raster_measure i_raster_measure (
		.clk_28  (clk_28),
		.arst_n  (arst_n),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n),
		.hblank  (hblank),
		.vblank  (vblank),
		.rst     (raster_bus.src)
	);

	crop_keys i_crop_keys (
		.clk_28     (clk_28),
		.arst_n     (arst_n),
		.key_strobe (key_strobe),
		.key_type   (key_type),
		.key_code   (key_cmd_pkg::key_code_t'(key_code)),   // raw byte to code
		.crop       (crop_bus.src)
	);

	blank_gen i_blank_gen (
		.clk_28  (clk_28),
		.arst_n  (arst_n),
		.rst     (raster_bus.dst),
		.crop    (crop_bus.dst),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n),
		.de      (de)
	);

	mode_snapshot i_mode_snapshot (
		.clk_28       (clk_28),
		.arst_n       (arst_n),
		.rst          (raster_bus.dst),
		.crop         (crop_bus.dst),
		.snap_hbl_l   (snap_hbl_l),
		.snap_hbl_r   (snap_hbl_r),
		.snap_vbl_t   (snap_vbl_t),
		.snap_vbl_b   (snap_vbl_b),
		.snap_hsize   (snap_hsize),
		.snap_vsize   (snap_vsize),
		.size_changes (size_changes)
	);

endmodule

`default_nettype wire

//--- mode_snapshot.sv
////////////////////
// per-frame snapshot
// crop offsets and picture size at frame start
// count of frames with a new size
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mode_snapshot (
	input  logic                  clk_28,
	input  logic                  arst_n,
	raster_if.dst                 rst,
	crop_if.dst                   crop,
	output video_timing_pkg::cnt_t snap_hbl_l,
	output video_timing_pkg::cnt_t snap_hbl_r,
	output video_timing_pkg::cnt_t snap_vbl_t,
	output video_timing_pkg::cnt_t snap_vbl_b,
	output video_timing_pkg::cnt_t snap_hsize,
	output video_timing_pkg::cnt_t snap_vsize,
	output logic [6:0]            size_changes   // wraps at 128
);

	logic size_new;   // measured size differs from held

	assign size_new = (rst.hsize != snap_hsize) || (rst.vsize != snap_vsize);

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			snap_hbl_l   <= '0;
			snap_hbl_r   <= '0;
			snap_vbl_t   <= '0;
			snap_vbl_b   <= '0;
			snap_hsize   <= '0;
			snap_vsize   <= '0;
			size_changes <= '0;
		end else if (rst.frame_start) begin
			snap_hbl_l <= crop.hbl_l;   // offsets in use this frame
			snap_hbl_r <= crop.hbl_r;
			snap_vbl_t <= crop.vbl_t;
			snap_vbl_b <= crop.vbl_b;
			snap_hsize <= rst.hsize;    // from previous frame
			snap_vsize <= rst.vsize;
			if (size_new)
				size_changes <= size_changes + 7'd1;
		end
	end

endmodule

`default_nettype wire

//--- blank_gen.sv
////////////////////
// blank and display-enable generator
// soft (crop) and forced blank, h and v
// registered h enable, de
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "crop_blank_config.svh"

module blank_gen (
	input  logic  clk_28,
	input  logic  arst_n,
	raster_if.dst rst,       // measured raster
	crop_if.dst   crop,      // crop offsets
	input  logic  hsync_n,
	input  logic  vsync_n,
	output logic  de         // display enable
);
	import video_timing_pkg::*;

	logic shbl, fhbl;          // soft / forced h blank
	logic svbl, fvbl;          // soft / forced v blank
	logic hbl, hbl_d, hbl_fall;
	logic hde;                 // ~hbl, one cycle late
	logic vs_d;
	cnt_t h_soft_clr, h_soft_set, h_force_set;
	cnt_t v_soft_clr, v_soft_set, v_force_set;

	assign h_soft_clr  = rst.hend + crop.hbl_l - cnt_t'(2);
	assign h_soft_set  = rst.hsta + crop.hbl_r - cnt_t'(2);
	assign h_force_set = rst.hmax - cnt_t'(`CB_H_FORCE_HI);
	assign v_soft_clr  = rst.vend + crop.vbl_t - cnt_t'(1);
	assign v_soft_set  = rst.vsta + crop.vbl_b - cnt_t'(1);
	assign v_force_set = rst.vmax - cnt_t'(`CB_V_FORCE_HI);

	assign hbl      = shbl | fhbl | ~hsync_n;
	assign hbl_fall = hbl_d & ~hbl;         // vertical flags step here
	assign de       = hde & ~(svbl | fvbl);

	////////////////////
	// horizontal, later match wins
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
			hde  <= 1'b0;
		end else begin
			if (rst.hcnt == h_soft_clr)                  shbl <= 1'b0;
			if (rst.hcnt == h_soft_set)                  shbl <= 1'b1;
			if (rst.hcnt == cnt_t'(`CB_H_FORCE_LO)) fhbl <= 1'b0;
			if (rst.hcnt == h_force_set)                 fhbl <= 1'b1;
			hde <= ~hbl;
		end
	end

	////////////////////
	// vertical, once per line
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			hbl_d <= 1'b1;
			vs_d  <= 1'b1;
			svbl  <= 1'b1;
			fvbl  <= 1'b1;
		end else begin
			hbl_d <= hbl;
			vs_d  <= vsync_n;
			if (hbl_fall) begin
				if (rst.vcnt == v_soft_clr)                  svbl <= 1'b0;
				if (rst.vcnt == v_soft_set)                  svbl <= 1'b1;
				if (rst.vcnt == cnt_t'(`CB_V_FORCE_LO)) fvbl <= 1'b0;
				if (rst.vcnt == v_force_set)                 fvbl <= 1'b1;
			end
			// vsync fall closes the picture even when vmax is stale
			if (vs_d && !vsync_n) fvbl <= 1'b1;
		end
	end

	// relies on hmax from raster_measure putting fhbl ahead of hsync
	a_de_hsync: assert property (@(posedge clk_28) disable iff (!arst_n)
		!hsync_n |-> !de)
		else $error("de high during hsync");

endmodule

`default_nettype wire

//--- crop_keys.sv
////////////////////
// adjust key decoder
// strobe edge detect, alt tracking, crop offsets
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "crop_blank_config.svh"

module crop_keys (
	input  logic                  clk_28,
	input  logic                  arst_n,
	input  logic                  key_strobe,   // rising edge marks a new key
	input  key_cmd_pkg::key_type_t key_type,
	input  key_cmd_pkg::key_code_t key_code,
	crop_if.src                   crop          // offsets out
);
	import key_cmd_pkg::*;
	import video_timing_pkg::*;

	logic      adj_q;     // registered adjust strobe
	logic      adj_d;     // for edge detect
	logic      key_hit;   // one new adjust key
	logic      alt;       // alt held
	key_code_t code_q;

	assign key_hit = adj_q & ~adj_d;

	////////////////////
	// input register
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			adj_q  <= 1'b0;
			adj_d  <= 1'b0;
			code_q <= key_code_t'(8'h00);
		end else begin
			adj_q  <= key_strobe && (key_type == key_type_t'(`CB_KEY_ADJ));
			adj_d  <= adj_q;
			code_q <= key_code;   // lines up with adj_q
		end
	end

	////////////////////
	// offsets
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			alt        <= 1'b0;
			crop.hbl_l <= '0;
			crop.hbl_r <= '0;
			crop.vbl_t <= '0;
			crop.vbl_b <= '0;
		end else if (key_hit) begin
			case (code_q)
				key_reset: begin
					crop.hbl_l <= '0;
					crop.hbl_r <= '0;
					crop.vbl_t <= '0;
					crop.vbl_b <= '0;
				end
				key_up: begin
					if (alt) crop.vbl_b <= crop.vbl_b + cnt_t'(`CB_V_STEP);
					else     crop.vbl_t <= crop.vbl_t + cnt_t'(`CB_V_STEP);
				end
				key_down: begin
					if (alt) crop.vbl_b <= crop.vbl_b - cnt_t'(`CB_V_STEP);
					else     crop.vbl_t <= crop.vbl_t - cnt_t'(`CB_V_STEP);
				end
				key_left: begin
					if (alt) crop.hbl_r <= crop.hbl_r + cnt_t'(`CB_H_STEP);
					else     crop.hbl_l <= crop.hbl_l + cnt_t'(`CB_H_STEP);
				end
				key_right: begin
					if (alt) crop.hbl_r <= crop.hbl_r - cnt_t'(`CB_H_STEP);
					else     crop.hbl_l <= crop.hbl_l - cnt_t'(`CB_H_STEP);
				end
				key_alt_l, key_alt_r:       alt <= 1'b1;
				key_alt_l_up, key_alt_r_up: alt <= 1'b0;
				default: ;   // other keys ignored
			endcase
		end
	end

	// arrow keys move one edge only
	a_one_offset: assert property (@(posedge clk_28) disable iff (!arst_n)
		(key_hit && code_q != key_reset) |=>
		$onehot0({$changed(crop.hbl_l), $changed(crop.hbl_r),
		          $changed(crop.vbl_t), $changed(crop.vbl_b)}))
		else $error("more than one crop offset changed on one key");

endmodule

`default_nettype wire

//--- raster_measure.sv
////////////////////
// raster measurement
// pixel and line counters, blank/sync edge positions
// picture size and frame start pulse
////////////////////

`timescale 1ns/1ps
`default_nettype none

module raster_measure (
	input  logic  clk_28,    // pixel clock
	input  logic  arst_n,
	input  logic  hsync_n,
	input  logic  vsync_n,
	input  logic  hblank,
	input  logic  vblank,
	raster_if.src rst        // measurements out
);
	import video_timing_pkg::*;

	logic hs_d, vs_d, hbl_d, vbl_d;   // previous input levels
	logic vbl_int;                    // vblank incl. vsync
	logic hs_fall, vs_fall;
	logic hbl_fall, hbl_rise;
	logic vbl_fall, vbl_rise;
	cnt_t vsta_p1;                    // first active line

	assign vbl_int  = vblank | ~vsync_n;
	assign hs_fall  = hs_d & ~hsync_n;
	assign vs_fall  = vs_d & ~vsync_n;
	assign hbl_fall = hbl_d & ~hblank;
	assign hbl_rise = ~hbl_d & hblank;
	assign vbl_fall = vbl_d & ~vbl_int;
	assign vbl_rise = ~vbl_d & vbl_int;
	assign vsta_p1  = rst.vsta + cnt_t'(1);

	assign rst.frame_start = vbl_fall;   // picture begins

	////////////////////
	// edge detect
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			hs_d  <= 1'b1;
			vs_d  <= 1'b1;
			hbl_d <= 1'b1;
			vbl_d <= 1'b1;
		end else begin
			hs_d  <= hsync_n;
			vs_d  <= vsync_n;
			hbl_d <= hblank;
			vbl_d <= vbl_int;
		end
	end

	////////////////////
	// counters and positions
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			rst.hcnt  <= '0;
			rst.vcnt  <= '0;
			rst.hend  <= '0;
			rst.hsta  <= '0;
			rst.hmax  <= '0;
			rst.vend  <= '0;
			rst.vsta  <= '0;
			rst.vmax  <= '0;
			rst.hsize <= '0;
			rst.vsize <= '0;
		end else begin
			rst.hcnt <= hsync_n ? rst.hcnt + cnt_t'(1) : '0;   // held in hsync
			if (!vsync_n)
				rst.vcnt <= '0;                            // held in vsync
			else if (hs_fall)
				rst.vcnt <= rst.vcnt + cnt_t'(1);

			if (hbl_fall) rst.hend <= rst.hcnt;
			if (hbl_rise) rst.hsta <= rst.hcnt;
			if (hs_fall)  rst.hmax <= rst.hcnt;              // line length
			if (vbl_fall) rst.vend <= rst.vcnt;
			if (vbl_rise) rst.vsta <= rst.vcnt;
			if (vs_fall)  rst.vmax <= rst.vcnt;              // frame height

			// width from the first line after vblank start
			if (hbl_rise && rst.vcnt == vsta_p1)
				rst.hsize <= rst.hcnt - rst.hend;
			if (vbl_rise)
				rst.vsize <= rst.vcnt - rst.vend;            // active lines
		end
	end

	// a line longer than the counter would wrap hcnt
	a_hcnt_range: assert property (@(posedge clk_28) disable iff (!arst_n)
		(rst.hcnt == '1) |-> !hsync_n)
		else $error("hcnt at top of range with hsync_n high");

endmodule

`default_nettype wire

//--- crop_if.sv
////////////////////
// crop offset bus
// left, right, top and bottom offsets
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface crop_if;
	import video_timing_pkg::*;

	cnt_t hbl_l;   // left crop, pixels
	cnt_t hbl_r;   // right crop, pixels
	cnt_t vbl_t;   // top crop, lines
	cnt_t vbl_b;   // bottom crop, lines

	// key decoder side
	modport src (
		output hbl_l, hbl_r,
		output vbl_t, vbl_b
	);

	// blanking and snapshot side
	modport dst (
		input hbl_l, hbl_r,
		input vbl_t, vbl_b
	);

endinterface

`default_nettype wire

//--- raster_if.sv
////////////////////
// measured raster bus
// counters, blank and sync edge positions, sizes
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface raster_if;
	import video_timing_pkg::*;

	cnt_t hcnt;          // pixel in line
	cnt_t vcnt;          // line in frame
	cnt_t hend;          // hcnt at hblank fall
	cnt_t hsta;          // hcnt at hblank rise
	cnt_t hmax;          // hcnt at hsync fall
	cnt_t vend;          // vcnt at vblank fall
	cnt_t vsta;          // vcnt at vblank rise
	cnt_t vmax;          // vcnt at vsync fall
	cnt_t hsize;         // active pixels
	cnt_t vsize;         // active lines
	logic frame_start;   // pulse, active picture begins

	// measurement side
	modport src (
		output hcnt, vcnt,
		output hend, hsta, hmax,
		output vend, vsta, vmax,
		output hsize, vsize,
		output frame_start
	);

	// blanking and snapshot side
	modport dst (
		input hcnt, vcnt,
		input hend, hsta, hmax,
		input vend, vsta, vmax,
		input hsize, vsize,
		input frame_start
	);

endinterface

`default_nettype wire

//--- key_cmd_pkg.sv
////////////////////
// keyboard types for the key path
// key code enumeration, key data type
////////////////////

`default_nettype none

package key_cmd_pkg;

	////////////////////
	// key codes
	typedef enum logic [7:0] {
		key_reset    = 8'h41,   // backspace, offsets to zero
		key_up       = 8'h4c,
		key_down     = 8'h4d,
		key_right    = 8'h4e,
		key_left     = 8'h4f,
		key_alt_l    = 8'h64,   // alt press
		key_alt_r    = 8'h65,
		key_alt_l_up = 8'he4,   // alt release
		key_alt_r_up = 8'he5
	} key_code_t;

	////////////////////
	// data type that comes with each code
	typedef logic [1:0] key_type_t;   // kbd, mouse, adjust...

endpackage

`default_nettype wire

//--- video_timing_pkg.sv
////////////////////
// raster types for the video modules
// counts, positions, sizes and crop offsets
////////////////////

`default_nettype none

`include "crop_blank_config.svh"

package video_timing_pkg;

	////////////////////
	// raster quantities

	// one type for pixel and line counts, edge positions,
	// picture sizes and crop offsets, so that the blanking
	// compares and sums all wrap at the same width
	typedef logic [`CB_CNT_W-1:0] cnt_t;   // wraps on overflow

	// offsets below zero are legal, down/right keys
	// past zero simply wrap and move the edge outwards

endpackage

`default_nettype wire

//--- crop_blank_config.svh
////////////////////
// build parameters for the crop and blank path
// counter width, crop steps per key
// forced blank margins, adjust key type
////////////////////

`ifndef CROP_BLANK_CONFIG_SVH
`define CROP_BLANK_CONFIG_SVH

////////////////////
// counters
`define CB_CNT_W 12          // width of all counters and offsets

////////////////////
// crop steps
`define CB_H_STEP 4          // pixels per left/right key
`define CB_V_STEP 1          // lines per up/down key

////////////////////
// forced blank margins
`define CB_H_FORCE_LO 8      // pixels after hsync rise
`define CB_H_FORCE_HI 8      // pixels before hsync fall
`define CB_V_FORCE_LO 1      // lines after vsync
`define CB_V_FORCE_HI 3      // lines before vsync fall

////////////////////
// keyboard
`define CB_KEY_ADJ 2'd3      // key type of adjust keys

`endif
